// ==== compile.f ====
+incdir+include
verilog/cpuPkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/hazardUnit.sv
verilog/datapath.sv
verilog/cpuCore.sv
testbench/storeChecker.sv
testbench/cpuCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps --top-module cpuCoreTb \
    -f compile.f -o cpuCoreSim

simOutput="$(./obj_dir/cpuCoreSim)"
echo "${simOutput}"

if ! grep -q "ALL TESTS PASSED" <<< "${simOutput}"; then
    exit 1
fi

// ==== testbench/cpu_patterns.txt ====
// first line holds the program length and the store count, then one program word per line
// after the program, one expected store per line as address then data
0000003D 00000014
// constants from lui, ori and addiu
3C011234 // 00 lui   r1, 0x1234
34215678 // 01 ori   r1, r1, 0x5678
2402FFFF // 02 addiu r2, r0, -1
34038000 // 03 ori   r3, r0, 0x8000
24048000 // 04 addiu r4, r0, 0x8000
AC010100 // 05 sw    r1, 0x100(r0)
AC020104 // 06 sw    r2, 0x104(r0)
AC030108 // 07 sw    r3, 0x108(r0)
AC04010C // 08 sw    r4, 0x10c(r0)
// register-register ALU operations
00222821 // 09 addu  r5, r1, r2
00613023 // 10 subu  r6, r3, r1
00243824 // 11 and   r7, r1, r4
00614025 // 12 or    r8, r3, r1
0041482A // 13 slt   r9, r2, r1
0022502A // 14 slt   r10, r1, r2
0061582A // 15 slt   r11, r3, r1
AC050110 // 16 sw    r5, 0x110(r0)
AC060114 // 17 sw    r6, 0x114(r0)
AC070118 // 18 sw    r7, 0x118(r0)
AC08011C // 19 sw    r8, 0x11c(r0)
AC090120 // 20 sw    r9, 0x120(r0)
AC0A0124 // 21 sw    r10, 0x124(r0)
AC0B0128 // 22 sw    r11, 0x128(r0)
// back-to-back dependent chain
240C0005 // 23 addiu r12, r0, 5
018C6821 // 24 addu  r13, r12, r12
01AC7021 // 25 addu  r14, r13, r12
01CD7823 // 26 subu  r15, r14, r13
AC0F012C // 27 sw    r15, 0x12c(r0)
// load followed by a dependent add
8C100100 // 28 lw    r16, 0x100(r0)
020C8821 // 29 addu  r17, r16, r12
AC110130 // 30 sw    r17, 0x130(r0)
// branches and jump, each with its delay slot
118F0002 // 31 beq   r12, r15, +2 taken
24120001 // 32 addiu r18, r0, 1
AC0001F0 // 33 sw    r0, 0x1f0(r0) skipped
AC120134 // 34 sw    r18, 0x134(r0)
158F0002 // 35 bne   r12, r15, +2 not taken
26520001 // 36 addiu r18, r18, 1
AC120138 // 37 sw    r18, 0x138(r0)
158E0002 // 38 bne   r12, r14, +2 taken
26520001 // 39 addiu r18, r18, 1
AC0001F4 // 40 sw    r0, 0x1f4(r0) skipped
AC12013C // 41 sw    r18, 0x13c(r0)
118E0002 // 42 beq   r12, r14, +2 not taken
26520001 // 43 addiu r18, r18, 1
AC120140 // 44 sw    r18, 0x140(r0)
08000030 // 45 j     48
26520001 // 46 addiu r18, r18, 1
AC0001F8 // 47 sw    r0, 0x1f8(r0) skipped
AC120144 // 48 sw    r18, 0x144(r0)
// branches on a fresh ALU result and on a fresh load
24130007 // 49 addiu r19, r0, 7
16600002 // 50 bne   r19, r0, +2 taken
26740001 // 51 addiu r20, r19, 1
AC0001FC // 52 sw    r0, 0x1fc(r0) skipped
AC140148 // 53 sw    r20, 0x148(r0)
8C150148 // 54 lw    r21, 0x148(r0)
12B40002 // 55 beq   r21, r20, +2 taken
26B60010 // 56 addiu r22, r21, 0x10
AC0001EC // 57 sw    r0, 0x1ec(r0) skipped
AC16014C // 58 sw    r22, 0x14c(r0)
0800003B // 59 j     59
00000000 // 60 nop
// expected stores in program order
00000100 12345678
00000104 FFFFFFFF
00000108 00008000
0000010C FFFF8000
00000110 12345677
00000114 EDCC2988
00000118 12340000
0000011C 1234D678
00000120 00000001
00000124 00000000
00000128 00000001
0000012C 00000005
00000130 1234567D
00000134 00000001
00000138 00000002
0000013C 00000003
00000140 00000004
00000144 00000005
00000148 00000008
0000014C 00000018

// ==== testbench/cpuCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

    localparam int PATTERN_DEPTH = 256;
    localparam int MEM_DEPTH = 256;
    localparam int MAX_STORES = 64;
    localparam int CYCLES_PER_WORD = 20;
    localparam int PIPE_DEPTH = 5;

    logic        clk;
    logic        arstN;
    logic [31:0] instrAddr;
    logic [31:0] instrData;
    logic [31:0] dataAddr;
    logic [31:0] dataWdata;
    logic [3:0]  dataWen;
    logic [31:0] dataRdata;
    logic [31:0] byteMask;

    logic [31:0] patterns [PATTERN_DEPTH];
    logic [31:0] instrRom [MEM_DEPTH];
    logic [31:0] dataRam [MEM_DEPTH];
    logic [63:0] expStores [MAX_STORES];
    logic [31:0] progCount;
    logic [31:0] storeCount;
    logic [31:0] seenCount;
    logic [31:0] passCount;
    logic [31:0] errorCount;
    logic        patternsLoaded;

    cpuCore u_cpuCore (
        .clk_i       (clk),
        .arstN_i     (arstN),
        .instrAddr_o (instrAddr),
        .instrData_i (instrData),
        .dataAddr_o  (dataAddr),
        .dataWdata_o (dataWdata),
        .dataWen_o   (dataWen),
        .dataRdata_i (dataRdata)
    );

    storeChecker u_storeChecker (
        .clk_i        (clk),
        .arstN_i      (arstN),
        .instrAddr_i  (instrAddr),
        .dataAddr_i   (dataAddr),
        .dataWdata_i  (dataWdata),
        .dataWen_i    (dataWen),
        .expStores_i  (expStores),
        .expCount_i   (storeCount),
        .seenCount_o  (seenCount),
        .passCount_o  (passCount),
        .errorCount_o (errorCount)
    );

    // word-addressed memories with combinational reads
    assign instrData = instrRom[instrAddr[9:2]];
    assign dataRdata = dataRam[dataAddr[9:2]];
    assign byteMask = {{8{dataWen[3]}}, {8{dataWen[2]}}, {8{dataWen[1]}}, {8{dataWen[0]}}};

    always @(posedge clk) begin
        if (!arstN) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                dataRam[8'(i)] <= '0;
            end
        end else if (dataWen != 4'h0) begin
            dataRam[dataAddr[9:2]] <= (dataRam[dataAddr[9:2]] & ~byteMask) |
                                      (dataWdata & byteMask);
        end
    end

    // header of two counts, then program words, then address and data pairs
    task automatic loadPatterns();
        logic [31:0] storeBase;
        $readmemh("testbench/cpu_patterns.txt", patterns);
        progCount = patterns[0];
        storeCount = patterns[1];
        storeBase = progCount + 32'd2;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            instrRom[8'(i)] = (i < progCount) ? patterns[8'(i + 2)] : 32'd0;
        end
        for (int i = 0; i < MAX_STORES; i++) begin
            expStores[6'(i)] = (i < storeCount) ?
                {patterns[8'(storeBase + 2 * i)], patterns[8'(storeBase + 2 * i + 1)]} :
                64'd0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        patternsLoaded = 1'b0;
        loadPatterns();
        patternsLoaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        arstN = 1'b1;
        while (seenCount < storeCount) begin
            @(posedge clk);
        end
        // let the pipeline empty so a stray store behind the last one is still caught
        repeat (PIPE_DEPTH) @(posedge clk);
        $display("Summary %0d of %0d stores seen, %0d checks passed, %0d failed",
                 seenCount, storeCount, passCount, errorCount);
        if (errorCount == 32'd0 && seenCount == storeCount) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // generous budget per program word that covers stalls
    initial begin
        wait (patternsLoaded);
        repeat (progCount * CYCLES_PER_WORD) @(posedge clk);
        $display("Timed out after %0d cycles with only %0d of %0d stores seen",
                 progCount * CYCLES_PER_WORD, seenCount, storeCount);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/storeChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module storeChecker (
    input  wire logic        clk_i,
    input  wire logic        arstN_i,
    input  wire logic [31:0] instrAddr_i,
    input  wire logic [31:0] dataAddr_i,
    input  wire logic [31:0] dataWdata_i,
    input  wire logic [3:0]  dataWen_i,
    // address in the upper word, data in the lower word
    input  wire logic [63:0] expStores_i [64],
    input  wire logic [31:0] expCount_i,
    output logic [31:0]      seenCount_o,
    output logic [31:0]      passCount_o,
    output logic [31:0]      errorCount_o
);

    // the program image starts at word 0 of the ROM
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    logic [31:0] expAddr;
    logic [31:0] expData;
    logic        resetChecked;

    // a store commits at the next rising edge, so the falling edge sees it settled
    always @(negedge clk_i) begin
        if (!arstN_i) begin
            seenCount_o = '0;
            passCount_o = '0;
            errorCount_o = '0;
            resetChecked = 1'b0;
        end else begin
            // first cycle out of reset, before the PC has moved
            if (!resetChecked) begin
                if (instrAddr_i !== RESET_PC) begin
                    $display("Fail instrAddr_o after reset expected %h actual %h",
                             RESET_PC, instrAddr_i);
                    errorCount_o = errorCount_o + 32'd1;
                end else if (dataWen_i !== 4'h0) begin
                    $display("Fail dataWen_o after reset expected %h actual %h",
                             4'h0, dataWen_i);
                    errorCount_o = errorCount_o + 32'd1;
                end else begin
                    $display("Reset state ok pc %h", instrAddr_i);
                    passCount_o = passCount_o + 32'd1;
                end
                resetChecked = 1'b1;
            end
            if (dataWen_i != 4'h0) begin
                if (seenCount_o >= expCount_i) begin
                    $display("Store %0d to address %h came after all %0d expected stores",
                             seenCount_o, dataAddr_i, expCount_i);
                    errorCount_o = errorCount_o + 32'd1;
                end else begin
                    expAddr = expStores_i[seenCount_o[5:0]][63:32];
                    expData = expStores_i[seenCount_o[5:0]][31:0];
                    if (dataAddr_i !== expAddr) begin
                        $display("Fail dataAddr_o store %0d expected %h actual %h",
                                 seenCount_o, expAddr, dataAddr_i);
                        errorCount_o = errorCount_o + 32'd1;
                    end else if (dataWdata_i !== expData) begin
                        $display("Fail dataWdata_o store %0d expected %h actual %h",
                                 seenCount_o, expData, dataWdata_i);
                        errorCount_o = errorCount_o + 32'd1;
                    end else begin
                        $display("Store %0d ok address %h data %h",
                                 seenCount_o, dataAddr_i, dataWdata_i);
                        passCount_o = passCount_o + 32'd1;
                    end
                end
                seenCount_o = seenCount_o + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cpuCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  wire logic        clk_i,
    input  wire logic        arstN_i,
    output logic [31:0]      instrAddr_o,
    input  wire logic [31:0] instrData_i,
    output logic [31:0]      dataAddr_o,
    output logic [31:0]      dataWdata_o,
    output logic [3:0]       dataWen_o,
    input  wire logic [31:0] dataRdata_i
);
    import cpuPkg::*;

    instrWord_u  decInstr;
    ctrl_t       decCtrl;
    logic [4:0]  rfRaddrA;
    logic [4:0]  rfRaddrB;
    logic [31:0] rfRdataA;
    logic [31:0] rfRdataB;
    memWb_t      wb;
    logic [31:0] aluA;
    logic [31:0] aluB;
    aluOp_e      aluOp;
    logic [31:0] aluResult;
    hzDec_t      hzDec;
    idEx_t       hzEx;
    exMem_t      hzMem;
    logic        stallFD;
    logic        flushEx;
    fwdSel_e     fwdExA;
    fwdSel_e     fwdExB;
    logic        fwdDecA;
    logic        fwdDecB;

    datapath u_datapath (
        .clk_i       (clk_i),
        .arstN_i     (arstN_i),
        .instrAddr_o (instrAddr_o),
        .instrData_i (instrData_i),
        .dataAddr_o  (dataAddr_o),
        .dataWdata_o (dataWdata_o),
        .dataWen_o   (dataWen_o),
        .dataRdata_i (dataRdata_i),
        .decInstr_o  (decInstr),
        .decCtrl_i   (decCtrl),
        .rfRaddrA_o  (rfRaddrA),
        .rfRaddrB_o  (rfRaddrB),
        .rfRdataA_i  (rfRdataA),
        .rfRdataB_i  (rfRdataB),
        .wb_o        (wb),
        .aluA_o      (aluA),
        .aluB_o      (aluB),
        .aluOp_o     (aluOp),
        .aluResult_i (aluResult),
        .hzDec_o     (hzDec),
        .hzEx_o      (hzEx),
        .hzMem_o     (hzMem),
        .stallFD_i   (stallFD),
        .flushEx_i   (flushEx),
        .fwdExA_i    (fwdExA),
        .fwdExB_i    (fwdExB),
        .fwdDecA_i   (fwdDecA),
        .fwdDecB_i   (fwdDecB)
    );

    instrDecoder u_instrDecoder (
        .instr_i (decInstr),
        .ctrl_o  (decCtrl)
    );

    regFile u_regFile (
        .clk_i    (clk_i),
        .arstN_i  (arstN_i),
        .raddrA_i (rfRaddrA),
        .raddrB_i (rfRaddrB),
        .rdataA_o (rfRdataA),
        .rdataB_o (rfRdataB),
        .wb_i     (wb)
    );

    aluUnit u_aluUnit (
        .a_i      (aluA),
        .b_i      (aluB),
        .op_i     (aluOp),
        .result_o (aluResult)
    );

    hazardUnit u_hazardUnit (
        .dec_i     (hzDec),
        .ex_i      (hzEx),
        .mem_i     (hzMem),
        .wb_i      (wb),
        .stallFD_o (stallFD),
        .flushEx_o (flushEx),
        .fwdExA_o  (fwdExA),
        .fwdExB_o  (fwdExB),
        .fwdDecA_o (fwdDecA),
        .fwdDecB_o (fwdDecB)
    );

endmodule

`default_nettype wire

// ==== verilog/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module datapath (
    input  wire logic               clk_i,
    input  wire logic               arstN_i,
    // instruction port
    output logic [31:0]             instrAddr_o,
    input  wire logic [31:0]        instrData_i,
    // data port
    output logic [31:0]             dataAddr_o,
    output logic [31:0]             dataWdata_o,
    output logic [3:0]              dataWen_o,
    input  wire logic [31:0]        dataRdata_i,
    // decoder
    output cpuPkg::instrWord_u      decInstr_o,
    input  wire cpuPkg::ctrl_t      decCtrl_i,
    // register file
    output logic [4:0]              rfRaddrA_o,
    output logic [4:0]              rfRaddrB_o,
    input  wire logic [31:0]        rfRdataA_i,
    input  wire logic [31:0]        rfRdataB_i,
    output cpuPkg::memWb_t          wb_o,
    // ALU
    output logic [31:0]             aluA_o,
    output logic [31:0]             aluB_o,
    output cpuPkg::aluOp_e          aluOp_o,
    input  wire logic [31:0]        aluResult_i,
    // hazard unit
    output cpuPkg::hzDec_t          hzDec_o,
    output cpuPkg::idEx_t           hzEx_o,
    output cpuPkg::exMem_t          hzMem_o,
    input  wire logic               stallFD_i,
    input  wire logic               flushEx_i,
    input  wire cpuPkg::fwdSel_e    fwdExA_i,
    input  wire cpuPkg::fwdSel_e    fwdExB_i,
    input  wire logic               fwdDecA_i,
    input  wire logic               fwdDecB_i
);
    import cpuPkg::*;

    // fetch
    logic [31:0] pc;
    logic [31:0] pcNext;
    logic [31:0] pcPlus4F;
    // decode
    instrWord_u  ifIdInstr;
    logic [31:0] ifIdPcPlus4;
    logic [31:0] decOpA;
    logic [31:0] decOpB;
    logic [31:0] decImm;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic        branchTaken;
    logic [4:0]  decDest;
    // later stages
    idEx_t       idEx;
    exMem_t      exMem;
    memWb_t      memWb;
    logic [31:0] exOpA;
    logic [31:0] exOpB;
    logic [31:0] wbValue;

    function automatic logic [31:0] pickOperand(
        input fwdSel_e     sel,
        input logic [31:0] regVal,
        input logic [31:0] memVal,
        input logic [31:0] wbVal
    );
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign pcPlus4F = pc + 32'd4;
    assign instrAddr_o = pc;

    // the delay slot is being fetched while the branch sits in decode
    assign pcNext = decCtrl_i.jump ? jumpTarget :
                    branchTaken    ? branchTarget : pcPlus4F;

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            pc <= `CPU_RESET_PC;
            ifIdInstr <= '0;
            ifIdPcPlus4 <= '0;
        end else if (!stallFD_i) begin
            pc <= pcNext;
            ifIdInstr <= instrData_i;
            ifIdPcPlus4 <= pcPlus4F;
        end
    end

    // decode
    assign decInstr_o = ifIdInstr;
    assign rfRaddrA_o = ifIdInstr.rType.rs;
    assign rfRaddrB_o = ifIdInstr.rType.rt;

    assign decOpA = fwdDecA_i ? exMem.aluResult : rfRdataA_i;
    assign decOpB = fwdDecB_i ? exMem.aluResult : rfRdataB_i;

    assign decImm = decCtrl_i.zeroExt ? {16'd0, ifIdInstr.iType.imm} :
                    {{16{ifIdInstr.iType.imm[15]}}, ifIdInstr.iType.imm};

    assign branchTarget = ifIdPcPlus4 + {decImm[29:0], 2'b00};
    // 26-bit jump index spans rs, rt and imm
    assign jumpTarget = {ifIdPcPlus4[31:28], ifIdInstr.iType.rs, ifIdInstr.iType.rt,
                         ifIdInstr.iType.imm, 2'b00};
    assign branchTaken = decCtrl_i.branch && ((decOpA == decOpB) != decCtrl_i.branchNe);

    assign decDest = decCtrl_i.regDst ? ifIdInstr.rType.rd : ifIdInstr.rType.rt;

    assign hzDec_o = '{
        rs:     ifIdInstr.rType.rs,
        rt:     ifIdInstr.rType.rt,
        branch: decCtrl_i.branch,
        jump:   decCtrl_i.jump
    };

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            idEx <= '0;
        end else if (flushEx_i) begin
            idEx <= '0;
        end else begin
            idEx <= '{
                ctrl:    decCtrl_i,
                pcPlus4: ifIdPcPlus4,
                rs:      ifIdInstr.rType.rs,
                rt:      ifIdInstr.rType.rt,
                destReg: decDest,
                opA:     decOpA,
                opB:     decOpB,
                imm:     decImm
            };
        end
    end

    // execute
    assign exOpA = pickOperand(fwdExA_i, idEx.opA, exMem.aluResult, wbValue);
    assign exOpB = pickOperand(fwdExB_i, idEx.opB, exMem.aluResult, wbValue);

    assign aluA_o = exOpA;
    assign aluB_o = idEx.ctrl.aluSrcImm ? idEx.imm : exOpB;
    assign aluOp_o = idEx.ctrl.aluOp;
    assign hzEx_o = idEx;

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            exMem <= '0;
        end else begin
            exMem <= '{
                ctrl:      idEx.ctrl,
                aluResult: aluResult_i,
                storeData: exOpB,
                destReg:   idEx.destReg
            };
        end
    end

    // memory stage drives word accesses only
    assign dataAddr_o = exMem.aluResult;
    assign dataWdata_o = exMem.storeData;
    assign dataWen_o = {4{exMem.ctrl.memWrite}};
    assign hzMem_o = exMem;

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            memWb <= '0;
        end else begin
            memWb <= '{
                regWrite:  exMem.ctrl.regWrite,
                memToReg:  exMem.ctrl.memToReg,
                aluResult: exMem.aluResult,
                loadData:  dataRdata_i,
                destReg:   exMem.destReg
            };
        end
    end

    // writeback
    assign wb_o = memWb;
    assign wbValue = memWb.memToReg ? memWb.loadData : memWb.aluResult;

    // word stores land on a word boundary
    wordStoreAligned: assert property (
        @(posedge clk_i) disable iff (!arstN_i)
            (dataWen_o != 4'h0) |-> (dataAddr_o[1:0] == 2'b00)
    );

    // the load-use stall keeps a load address from being forwarded as data
    memFwdNotLoad: assert property (
        @(posedge clk_i) disable iff (!arstN_i)
            (!idEx.ctrl.jump && (fwdExA_i == FWD_MEM || fwdExB_i == FWD_MEM))
                |-> !exMem.ctrl.memToReg
    );

endmodule

`default_nettype wire

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire cpuPkg::hzDec_t dec_i,
    input  wire cpuPkg::idEx_t  ex_i,
    input  wire cpuPkg::exMem_t mem_i,
    input  wire cpuPkg::memWb_t wb_i,
    output logic                stallFD_o,
    output logic                flushEx_o,
    output cpuPkg::fwdSel_e     fwdExA_o,
    output cpuPkg::fwdSel_e     fwdExB_o,
    output logic                fwdDecA_o,
    output logic                fwdDecB_o
);
    import cpuPkg::*;

    logic exWrites;
    logic memWrites;
    logic wbWrites;
    logic exHitsDec;
    logic memLoadHitsDec;
    logic loadUse;
    logic branchOnEx;
    logic branchOnLoad;

    assign exWrites  = ex_i.ctrl.regWrite && (ex_i.destReg != 5'd0);
    assign memWrites = mem_i.ctrl.regWrite && (mem_i.destReg != 5'd0);
    assign wbWrites  = wb_i.regWrite && (wb_i.destReg != 5'd0);

    // execute operands take the newest producer
    assign fwdExA_o = (memWrites && mem_i.destReg == ex_i.rs) ? FWD_MEM :
                      (wbWrites && wb_i.destReg == ex_i.rs)   ? FWD_WB  : FWD_NONE;
    assign fwdExB_o = (memWrites && mem_i.destReg == ex_i.rt) ? FWD_MEM :
                      (wbWrites && wb_i.destReg == ex_i.rt)   ? FWD_WB  : FWD_NONE;

    // branch compare only takes ALU results from memory
    assign fwdDecA_o = memWrites && !mem_i.ctrl.memToReg && mem_i.destReg == dec_i.rs;
    assign fwdDecB_o = memWrites && !mem_i.ctrl.memToReg && mem_i.destReg == dec_i.rt;

    assign exHitsDec = exWrites && (ex_i.destReg == dec_i.rs || ex_i.destReg == dec_i.rt);
    assign memLoadHitsDec = memWrites && mem_i.ctrl.memToReg &&
                            (mem_i.destReg == dec_i.rs || mem_i.destReg == dec_i.rt);

    // J carries a target where rs and rt would be
    assign loadUse      = exHitsDec && ex_i.ctrl.memToReg && !dec_i.jump;
    assign branchOnEx   = exHitsDec && dec_i.branch;
    assign branchOnLoad = memLoadHitsDec && dec_i.branch;

    // hold fetch and decode, send a bubble down
    assign stallFD_o = loadUse || branchOnEx || branchOnLoad;
    assign flushEx_o = stallFD_o;

endmodule

`default_nettype wire

// ==== verilog/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  wire logic [31:0]    a_i,
    input  wire logic [31:0]    b_i,
    input  wire cpuPkg::aluOp_e op_i,
    output logic [31:0]         result_o
);
    import cpuPkg::*;

    logic lessThan;

    // signed compare for SLT
    assign lessThan = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_SLT: result_o = {31'd0, lessThan};
            // immediate arrives zero-extended in b
            ALU_LUI: result_o = {b_i[15:0], 16'd0};
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic           clk_i,
    input  wire logic           arstN_i,
    input  wire logic [4:0]     raddrA_i,
    input  wire logic [4:0]     raddrB_i,
    output logic [31:0]         rdataA_o,
    output logic [31:0]         rdataB_o,
    input  wire cpuPkg::memWb_t wb_i
);

    logic [31:0] regs [32];
    logic [31:0] wdata;
    logic        wen;

    // writeback value is the loaded word or the ALU result
    assign wdata = wb_i.memToReg ? wb_i.loadData : wb_i.aluResult;
    // register 0 is never a target
    assign wen = wb_i.regWrite && (wb_i.destReg != 5'd0);

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[wb_i.destReg] <= wdata;
        end
    end

    // same-cycle write passes straight to the readers
    assign rdataA_o = (wen && wb_i.destReg == raddrA_i) ? wdata : regs[raddrA_i];
    assign rdataB_o = (wen && wb_i.destReg == raddrB_i) ? wdata : regs[raddrB_i];

    // a write never stores an unknown value
    writeDataKnown: assert property (
        @(posedge clk_i) disable iff (!arstN_i) wen |-> !$isunknown(wdata)
    );

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module instrDecoder (
    input  wire cpuPkg::instrWord_u instr_i,
    output cpuPkg::ctrl_t           ctrl_o
);
    import cpuPkg::*;

    always_comb begin
        // anything not listed below stays a bubble
        ctrl_o = '0;
        ctrl_o.aluOp = ALU_ADD;
        case (instr_i.iType.op)
            `CPU_OP_RTYPE: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.regDst = 1'b1;
                case (instr_i.rType.funct)
                    `CPU_FN_ADDU: ctrl_o.aluOp = ALU_ADD;
                    `CPU_FN_SUBU: ctrl_o.aluOp = ALU_SUB;
                    `CPU_FN_AND:  ctrl_o.aluOp = ALU_AND;
                    `CPU_FN_OR:   ctrl_o.aluOp = ALU_OR;
                    `CPU_FN_SLT:  ctrl_o.aluOp = ALU_SLT;
                    default: begin
                        ctrl_o.regWrite = 1'b0;
                        ctrl_o.regDst = 1'b0;
                    end
                endcase
            end
            `CPU_OP_ADDIU: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
            end
            `CPU_OP_ORI: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.zeroExt = 1'b1;
                ctrl_o.aluOp = ALU_OR;
            end
            `CPU_OP_LUI: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.zeroExt = 1'b1;
                ctrl_o.aluOp = ALU_LUI;
            end
            `CPU_OP_LW: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.memToReg = 1'b1;
            end
            `CPU_OP_SW: begin
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.memWrite = 1'b1;
            end
            `CPU_OP_BEQ: begin
                ctrl_o.branch = 1'b1;
            end
            `CPU_OP_BNE: begin
                ctrl_o.branch = 1'b1;
                ctrl_o.branchNe = 1'b1;
            end
            `CPU_OP_J: begin
                ctrl_o.jump = 1'b1;
            end
            default: begin
                ctrl_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/cpuPkg.sv ====
`default_nettype none
`include "cpu_consts.svh"

package cpuPkg;

    typedef enum logic [3:0] {
        ALU_ADD = `CPU_ALU_ADD,
        ALU_SUB = `CPU_ALU_SUB,
        ALU_AND = `CPU_ALU_AND,
        ALU_OR  = `CPU_ALU_OR,
        ALU_SLT = `CPU_ALU_SLT,
        ALU_LUI = `CPU_ALU_LUI
    } aluOp_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwdSel_e;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rType_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iType_t;

    // one instruction word, two layouts
    typedef union packed {
        rType_t rType;
        iType_t iType;
    } instrWord_u;

    typedef struct packed {
        logic   regWrite;
        logic   regDst;
        logic   aluSrcImm;
        logic   zeroExt;
        logic   memToReg;
        logic   memWrite;
        logic   branch;
        logic   branchNe;
        logic   jump;
        aluOp_e aluOp;
    } ctrl_t;

    // decode-stage fields seen by the hazard unit
    typedef struct packed {
        logic [4:0] rs;
        logic [4:0] rt;
        logic       branch;
        logic       jump;
    } hzDec_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] pcPlus4;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  destReg;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] imm;
    } idEx_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] aluResult;
        logic [31:0] storeData;
        logic [4:0]  destReg;
    } exMem_t;

    typedef struct packed {
        logic        regWrite;
        logic        memToReg;
        logic [31:0] aluResult;
        logic [31:0] loadData;
        logic [4:0]  destReg;
    } memWb_t;

endpackage

`default_nettype wire

// ==== include/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// first instruction fetched after reset
`define CPU_RESET_PC 32'h0000_0000

// primary opcodes
`define CPU_OP_RTYPE 6'h00
`define CPU_OP_J     6'h02
`define CPU_OP_BEQ   6'h04
`define CPU_OP_BNE   6'h05
`define CPU_OP_ADDIU 6'h09
`define CPU_OP_ORI   6'h0D
`define CPU_OP_LUI   6'h0F
`define CPU_OP_LW    6'h23
`define CPU_OP_SW    6'h2B

// funct field of R-type
`define CPU_FN_ADDU 6'h21
`define CPU_FN_SUBU 6'h23
`define CPU_FN_AND  6'h24
`define CPU_FN_OR   6'h25
`define CPU_FN_SLT  6'h2A

// ALU operation codes
`define CPU_ALU_ADD 4'd0
`define CPU_ALU_SUB 4'd1
`define CPU_ALU_AND 4'd2
`define CPU_ALU_OR  4'd3
`define CPU_ALU_SLT 4'd4
`define CPU_ALU_LUI 4'd5

`endif
